/* hdl/fp_format_pkg.sv */
package fp_format_pkg;

  // IEEE 754 binary32 layout
  parameter int SP_WIDTH     = 32;
  parameter int SP_EXP_WIDTH = 8;
  parameter int SP_MAN_WIDTH = 23;

  // IEEE 754 binary64 layout
  parameter int DP_WIDTH     = 64;
  parameter int DP_EXP_WIDTH = 11;
  parameter int DP_MAN_WIDTH = 52;

  typedef logic [DP_WIDTH-1:0] dword_t;
  typedef logic [SP_WIDTH-1:0] word_t;

  // Quiet NaNs with only exponent and top mantissa bit set
  parameter dword_t DP_CANONICAL_NAN = 64'h7ff8_0000_0000_0000;
  // Single NaN sits boxed in the upper word of ones
  parameter dword_t SP_CANONICAL_NAN = 64'hffff_ffff_7fc0_0000;

  // Accrued exception flags with nv as the MSB
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  // FCLASS mask starting with n_inf on bit 0
  typedef struct packed {
    logic q_nan;
    logic sig_nan;
    logic p_inf;
    logic p_norm;
    logic p_sub;
    logic p_zero;
    logic n_zero;
    logic n_sub;
    logic n_norm;
    logic n_inf;
  } fclass_t;

endpackage

/* hdl/fpu_op_pkg.sv */
package fpu_op_pkg;

  typedef enum logic [3:0] {
    op_fsgnj  = 4'd0,
    op_fsgnjn = 4'd1,
    op_fsgnjx = 4'd2,
    op_fmin   = 4'd3,
    op_fmax   = 4'd4,
    op_feq    = 4'd5,
    op_flt    = 4'd6,
    op_fle    = 4'd7,
    op_fclass = 4'd8,
    // Float register to integer register
    op_fmvi   = 4'd9,
    // Integer register to float register
    op_imvf   = 4'd10
  } fpu_op_e;

  typedef enum logic {
    pr_single = 1'b0,
    pr_double = 1'b1
  } fp_pr_e;

  // Operand category decoded straight from the IEEE fields
  typedef struct packed {
    logic sign;
    logic is_nan;
    logic is_snan;
    logic is_inf;
    logic is_zero;
    logic is_sub;
    logic is_norm;
    logic spare;
  } operand_class_t;

  typedef struct packed {
    fp_format_pkg::dword_t  value;
    fp_format_pkg::fflags_t flags;
  } unit_result_t;

endpackage

/* hdl/fpu_operand_unbox.sv */
module fpu_operand_unbox (
  input  fp_format_pkg::dword_t      a_i,
  input  fp_format_pkg::dword_t      b_i,
  input  fpu_op_pkg::fp_pr_e         ipr_i,
  output fp_format_pkg::dword_t      a_val_o,
  output fp_format_pkg::dword_t      b_val_o,
  output fpu_op_pkg::operand_class_t a_class_o,
  output fpu_op_pkg::operand_class_t b_class_o
);

  import fp_format_pkg::*;
  import fpu_op_pkg::*;

  function automatic operand_class_t classify(input dword_t val, input fp_pr_e pr);
    logic           sgn;
    logic           exp_ones;
    logic           exp_zero;
    logic           man_zero;
    logic           man_top;
    operand_class_t cls;
    if (pr == pr_double)
    begin
      sgn      = val[DP_WIDTH-1];
      exp_ones = &val[DP_MAN_WIDTH +: DP_EXP_WIDTH];
      exp_zero = ~|val[DP_MAN_WIDTH +: DP_EXP_WIDTH];
      man_zero = ~|val[DP_MAN_WIDTH-1:0];
      man_top  = val[DP_MAN_WIDTH-1];
    end
    else
    begin
      sgn      = val[SP_WIDTH-1];
      exp_ones = &val[SP_MAN_WIDTH +: SP_EXP_WIDTH];
      exp_zero = ~|val[SP_MAN_WIDTH +: SP_EXP_WIDTH];
      man_zero = ~|val[SP_MAN_WIDTH-1:0];
      man_top  = val[SP_MAN_WIDTH-1];
    end
    cls.sign    = sgn;
    cls.is_nan  = exp_ones & ~man_zero;
    // Signalling when the quiet bit is clear
    cls.is_snan = exp_ones & ~man_zero & ~man_top;
    cls.is_inf  = exp_ones & man_zero;
    cls.is_zero = exp_zero & man_zero;
    cls.is_sub  = exp_zero & ~man_zero;
    cls.is_norm = ~exp_ones & ~exp_zero;
    cls.spare   = 1'b0;
    return cls;
  endfunction

  logic a_boxed;
  logic b_boxed;

  // A single is valid only with the upper word all ones
  assign a_boxed = (ipr_i == pr_double) | (&a_i[DP_WIDTH-1:SP_WIDTH]);
  assign b_boxed = (ipr_i == pr_double) | (&b_i[DP_WIDTH-1:SP_WIDTH]);

  assign a_val_o = a_boxed ? a_i : SP_CANONICAL_NAN;
  assign b_val_o = b_boxed ? b_i : SP_CANONICAL_NAN;

  assign a_class_o = classify(a_val_o, ipr_i);
  assign b_class_o = classify(b_val_o, ipr_i);

endmodule

/* hdl/fpu_compare_unit.sv */
module fpu_compare_unit (
  input  fp_format_pkg::dword_t      a_val_i,
  input  fp_format_pkg::dword_t      b_val_i,
  input  fpu_op_pkg::operand_class_t a_class_i,
  input  fpu_op_pkg::operand_class_t b_class_i,
  input  fpu_op_pkg::fpu_op_e        op_i,
  input  fpu_op_pkg::fp_pr_e         opr_i,
  output fpu_op_pkg::unit_result_t   res_o
);

  import fp_format_pkg::*;
  import fpu_op_pkg::*;

  logic [DP_WIDTH-2:0] a_mag;
  logic [DP_WIDTH-2:0] b_mag;
  logic                mag_lt;
  logic                mag_eq;
  logic                both_zero;
  logic                unordered;
  logic                any_snan;
  logic                ord_eq;
  logic                ord_lt;
  logic                a_below;
  logic                signaling;
  logic                quiet_nv;
  dword_t              canonical;
  dword_t              min_val;
  dword_t              max_val;

  // Sign-free magnitudes with singles zero extended
  assign a_mag = (opr_i == pr_double) ? a_val_i[DP_WIDTH-2:0]
                                      : (DP_WIDTH-1)'(a_val_i[SP_WIDTH-2:0]);
  assign b_mag = (opr_i == pr_double) ? b_val_i[DP_WIDTH-2:0]
                                      : (DP_WIDTH-1)'(b_val_i[SP_WIDTH-2:0]);

  assign mag_lt    = a_mag < b_mag;
  assign mag_eq    = a_mag == b_mag;
  assign both_zero = a_class_i.is_zero & b_class_i.is_zero;
  assign unordered = a_class_i.is_nan | b_class_i.is_nan;
  assign any_snan  = a_class_i.is_snan | b_class_i.is_snan;

  // +0 and -0 compare equal
  assign ord_eq = both_zero | ((a_class_i.sign == b_class_i.sign) & mag_eq);

  always_comb
  begin
    if (both_zero)
      ord_lt = 1'b0;
    else if (a_class_i.sign != b_class_i.sign)
      ord_lt = a_class_i.sign;
    else if (!a_class_i.sign)
      ord_lt = mag_lt;
    else
      ord_lt = ~mag_lt & ~mag_eq;
  end

  // For min/max a negative zero sits below a positive one
  assign a_below = ord_lt | (both_zero & a_class_i.sign & ~b_class_i.sign);

  assign canonical = (opr_i == pr_double) ? DP_CANONICAL_NAN : SP_CANONICAL_NAN;

  always_comb
  begin
    if (a_class_i.is_nan && b_class_i.is_nan)
    begin
      min_val = canonical;
      max_val = canonical;
    end
    else if (a_class_i.is_nan)
    begin
      min_val = b_val_i;
      max_val = b_val_i;
    end
    else if (b_class_i.is_nan)
    begin
      min_val = a_val_i;
      max_val = a_val_i;
    end
    else
    begin
      min_val = a_below ? a_val_i : b_val_i;
      max_val = a_below ? b_val_i : a_val_i;
    end
  end

  assign signaling = (op_i == op_flt) | (op_i == op_fle);
  assign quiet_nv  = op_i inside {op_feq, op_fmin, op_fmax};

  always_comb
  begin
    res_o.value = '0;
    res_o.flags = '{nv: (signaling & unordered) | (quiet_nv & any_snan), default: 1'b0};
    unique case (op_i)
      op_feq:  res_o.value = dword_t'(~unordered & ord_eq);
      op_flt:  res_o.value = dword_t'(~unordered & ord_lt);
      op_fle:  res_o.value = dword_t'(~unordered & (ord_lt | ord_eq));
      op_fmin: res_o.value = min_val;
      op_fmax: res_o.value = max_val;
      default: res_o.value = '0;
    endcase
  end

endmodule

/* hdl/fpu_bitwise_unit.sv */
module fpu_bitwise_unit (
  input  fp_format_pkg::dword_t      a_i,
  input  fp_format_pkg::dword_t      a_val_i,
  input  fp_format_pkg::dword_t      b_val_i,
  input  fpu_op_pkg::operand_class_t a_class_i,
  input  fpu_op_pkg::fpu_op_e        op_i,
  input  fpu_op_pkg::fp_pr_e         opr_i,
  output fpu_op_pkg::unit_result_t   res_o
);

  import fp_format_pkg::*;
  import fpu_op_pkg::*;

  logic    a_sgn;
  logic    b_sgn;
  logic    inj_sgn;
  word_t   a_word;
  dword_t  fsgn_val;
  fclass_t fclass_val;

  assign a_sgn = (opr_i == pr_double) ? a_val_i[DP_WIDTH-1] : a_val_i[SP_WIDTH-1];
  assign b_sgn = (opr_i == pr_double) ? b_val_i[DP_WIDTH-1] : b_val_i[SP_WIDTH-1];

  always_comb
  begin
    unique case (op_i)
      op_fsgnjn: inj_sgn = ~b_sgn;
      op_fsgnjx: inj_sgn = a_sgn ^ b_sgn;
      default:   inj_sgn = b_sgn;
    endcase
  end

  // Singles come back boxed
  assign fsgn_val = (opr_i == pr_double)
                    ? {inj_sgn, a_val_i[DP_WIDTH-2:0]}
                    : {{SP_WIDTH{1'b1}}, inj_sgn, a_val_i[SP_WIDTH-2:0]};

  assign fclass_val = '{
    q_nan:   a_class_i.is_nan & ~a_class_i.is_snan,
    sig_nan: a_class_i.is_snan,
    p_inf:   ~a_class_i.sign & a_class_i.is_inf,
    p_norm:  ~a_class_i.sign & a_class_i.is_norm,
    p_sub:   ~a_class_i.sign & a_class_i.is_sub,
    p_zero:  ~a_class_i.sign & a_class_i.is_zero,
    n_zero:  a_class_i.sign & a_class_i.is_zero,
    n_sub:   a_class_i.sign & a_class_i.is_sub,
    n_norm:  a_class_i.sign & a_class_i.is_norm,
    n_inf:   a_class_i.sign & a_class_i.is_inf
  };

  // Moves look at the raw register, not the unboxed copy
  assign a_word = a_i[SP_WIDTH-1:0];

  always_comb
  begin
    res_o.flags = '0;
    unique case (op_i)
      op_fsgnj, op_fsgnjn, op_fsgnjx:
        res_o.value = fsgn_val;
      op_fclass:
        res_o.value = dword_t'(fclass_val);
      op_fmvi:
        res_o.value = (opr_i == pr_double) ? a_val_i : dword_t'($signed(a_word));
      op_imvf:
        res_o.value = (opr_i == pr_double) ? a_i : {{SP_WIDTH{1'b1}}, a_word};
      default:
        res_o.value = '0;
    endcase
  end

endmodule

/* hdl/fpu_result_pipe.sv */
module fpu_result_pipe #(
  parameter int LATENCY = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  fpu_op_pkg::fpu_op_e      op_i,
  input  fpu_op_pkg::unit_result_t cmp_res_i,
  input  fpu_op_pkg::unit_result_t bit_res_i,
  output fp_format_pkg::dword_t    result_o,
  output fp_format_pkg::fflags_t   eflags_o
);

  import fpu_op_pkg::*;

  // One stage fewer than the nominal latency
  localparam int STAGES = LATENCY - 1;

  logic                            is_cmp_op;
  unit_result_t                    sel_res;
  unit_result_t [STAGES-1:0]       stage_q;

  assign is_cmp_op = op_i inside {op_fmin, op_fmax, op_feq, op_flt, op_fle};
  assign sel_res   = is_cmp_op ? cmp_res_i : bit_res_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      stage_q <= '0;
    end
    else
    begin
      stage_q[0] <= sel_res;
      for (int i = 1; i < STAGES; i++)
      begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign result_o = stage_q[STAGES-1].value;
  assign eflags_o = stage_q[STAGES-1].flags;

endmodule

/* hdl/fpu_noncomp_top.sv */
module fpu_noncomp_top #(
  parameter int LATENCY = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  fp_format_pkg::dword_t  a_i,
  input  fp_format_pkg::dword_t  b_i,
  input  fpu_op_pkg::fpu_op_e    op_i,
  input  fpu_op_pkg::fp_pr_e     ipr_i,
  input  fpu_op_pkg::fp_pr_e     opr_i,
  output fp_format_pkg::dword_t  result_o,
  output fp_format_pkg::fflags_t eflags_o
);

  import fp_format_pkg::*;
  import fpu_op_pkg::*;

  dword_t         a_val;
  dword_t         b_val;
  operand_class_t a_class;
  operand_class_t b_class;
  unit_result_t   cmp_res;
  unit_result_t   bit_res;

  fpu_operand_unbox u_unbox (
    .a_i       (a_i),
    .b_i       (b_i),
    .ipr_i     (ipr_i),
    .a_val_o   (a_val),
    .b_val_o   (b_val),
    .a_class_o (a_class),
    .b_class_o (b_class)
  );

  fpu_compare_unit u_compare (
    .a_val_i   (a_val),
    .b_val_i   (b_val),
    .a_class_i (a_class),
    .b_class_i (b_class),
    .op_i      (op_i),
    .opr_i     (opr_i),
    .res_o     (cmp_res)
  );

  fpu_bitwise_unit u_bitwise (
    .a_i       (a_i),
    .a_val_i   (a_val),
    .b_val_i   (b_val),
    .a_class_i (a_class),
    .op_i      (op_i),
    .opr_i     (opr_i),
    .res_o     (bit_res)
  );

  fpu_result_pipe #(
    .LATENCY (LATENCY)
  ) u_result_pipe (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .op_i      (op_i),
    .cmp_res_i (cmp_res),
    .bit_res_i (bit_res),
    .result_o  (result_o),
    .eflags_o  (eflags_o)
  );

endmodule

/* dv/fpu_properties.sv */
module fpu_properties #(
  parameter int LATENCY = 4
) (
  input logic                   clk_i,
  input logic                   rst_i,
  input fpu_op_pkg::fpu_op_e    op_i,
  input fp_format_pkg::dword_t  result_i,
  input fp_format_pkg::fflags_t eflags_i
);

  import fpu_op_pkg::*;

  reset_clears: assert property (@(posedge clk_i)
    rst_i |=> (result_i == '0) && (eflags_i == '0))
    else $error("Result or flags not cleared after reset");

  // Only invalid can ever be raised by these operations
  only_nv_flag: assert property (@(posedge clk_i) disable iff (rst_i)
    !(eflags_i.dz | eflags_i.of | eflags_i.uf | eflags_i.nx))
    else $error("Flag other than nv raised");

  compare_bit0: assert property (@(posedge clk_i) disable iff (rst_i)
    (($past(op_i, LATENCY-1) == op_feq) || ($past(op_i, LATENCY-1) == op_flt) ||
     ($past(op_i, LATENCY-1) == op_fle)) |-> (result_i[63:1] == '0))
    else $error("Compare result has bits set above bit 0");

endmodule

/* dv/fpu_tb.sv */
module fpu_tb;

  import fp_format_pkg::*;
  import fpu_op_pkg::*;

  localparam int LATENCY = 4;

  typedef struct packed {
    logic [3:0] group;
    fpu_op_e    op;
    fp_pr_e     ipr;
    fp_pr_e     opr;
    dword_t     a;
    dword_t     b;
    dword_t     exp_res;
    fflags_t    exp_flags;
  } vector_t;

  // Vector plus the cycle its result shows up
  typedef struct packed {
    vector_t     vec;
    logic [31:0] due;
  } pending_t;

  logic        clk;
  logic        rst;
  dword_t      a;
  dword_t      b;
  fpu_op_e     op;
  fp_pr_e      ipr;
  fp_pr_e      opr;
  dword_t      result;
  fflags_t     eflags;
  vector_t     vec_q[$];
  pending_t    pend_q[$];
  logic [31:0] cycle_cnt = '0;
  logic [3:0]  cur_group = '0;
  logic        loaded = 1'b0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          group_pass[16];
  int          group_fail[16];

  fpu_noncomp_top #(
    .LATENCY (LATENCY)
  ) UUT (
    .clk_i    (clk),
    .rst_i    (rst),
    .a_i      (a),
    .b_i      (b),
    .op_i     (op),
    .ipr_i    (ipr),
    .opr_i    (opr),
    .result_o (result),
    .eflags_o (eflags)
  );

  bind fpu_noncomp_top fpu_properties #(
    .LATENCY (LATENCY)
  ) u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .op_i     (op_i),
    .result_i (result_o),
    .eflags_i (eflags_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic load_vectors();
    int         fd;
    int         grp;
    int         n;
    string      line;
    logic [3:0] op_raw;
    logic       ipr_raw;
    logic       opr_raw;
    dword_t     a_raw;
    dword_t     b_raw;
    dword_t     res_raw;
    logic [4:0] flg_raw;
    vector_t    v;
    fd = $fopen("dv/fpu_input.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the vector file dv/fpu_input.txt");
      fail_cnt++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line[0] != "#")
        begin
          n = $sscanf(line, "%d %h %h %h %h %h %h %h", grp, op_raw, ipr_raw, opr_raw,
                      a_raw, b_raw, res_raw, flg_raw);
          if (n == 8)
          begin
            v.group     = grp[3:0];
            v.op        = fpu_op_e'(op_raw);
            v.ipr       = fp_pr_e'(ipr_raw);
            v.opr       = fp_pr_e'(opr_raw);
            v.a         = a_raw;
            v.b         = b_raw;
            v.exp_res   = res_raw;
            v.exp_flags = flg_raw;
            vec_q.push_back(v);
          end
        end
      end
      $fclose(fd);
    end
    if (vec_q.size() == 0)
    begin
      $display("No test vectors were loaded");
      fail_cnt++;
    end
  endtask

  task automatic drive_vector(input vector_t v);
    pending_t p;
    a     = v.a;
    b     = v.b;
    op    = v.op;
    ipr   = v.ipr;
    opr   = v.opr;
    p.vec = v;
    p.due = cycle_cnt + LATENCY - 1;
    pend_q.push_back(p);
  endtask

  task automatic print_group_summary(input logic [3:0] g);
    $display("Group %0d finished: %0d checked, %0d mismatched",
             g, group_pass[g] + group_fail[g], group_fail[g]);
  endtask

  task automatic check_result(input vector_t v);
    if (v.group != cur_group)
    begin
      if (cur_group != 0)
        print_group_summary(cur_group);
      cur_group = v.group;
    end
    assert (result == v.exp_res && eflags == v.exp_flags)
    begin
      pass_cnt++;
      group_pass[v.group]++;
    end
    else
    begin
      $display("MISMATCH at time %0t: %s expected %h flags %h, got %h flags %h",
               $time, v.op.name(), v.exp_res, v.exp_flags, result, eflags);
      fail_cnt++;
      group_fail[v.group]++;
    end
  endtask

  always @(negedge clk)
  begin
    pending_t p;
    while (pend_q.size() > 0 && pend_q[0].due == cycle_cnt)
    begin
      p = pend_q.pop_front();
      check_result(p.vec);
    end
  end

  initial
  begin
    rst = 1'b1;
    a   = '0;
    b   = '0;
    op  = op_fsgnj;
    ipr = pr_double;
    opr = pr_double;
    foreach (group_pass[i])
    begin
      group_pass[i] = 0;
      group_fail[i] = 0;
    end
    load_vectors();
    loaded = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    // Pipe must be empty right after reset
    assert (result == '0 && eflags == '0)
    begin
      pass_cnt++;
      group_pass[6]++;
    end
    else
    begin
      $display("MISMATCH at time %0t: outputs not zero after reset, got %h flags %h",
               $time, result, eflags);
      fail_cnt++;
      group_fail[6]++;
    end
    foreach (vec_q[i])
    begin
      @(posedge clk);
      #1;
      drive_vector(vec_q[i]);
    end
    wait (pend_q.size() == 0);
    #1;
    if (cur_group != 0)
      print_group_summary(cur_group);
    $display("Checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    wait (loaded);
    #((vec_q.size() + 16 + LATENCY + 20) * 4);
    $display("Run timed out before every vector was checked");
    $display("Test failed");
    $finish;
  end

endmodule

/* dv/fpu_input.txt */
# group op ipr opr a b expected_result expected_flags (group decimal, rest hex)
# op 0 sgnj 1 sgnjn 2 sgnjx 3 min 4 max 5 eq 6 lt 7 le 8 class 9 mv.x a mv.f, pr 0 single 1 double
1 0 1 1 3ff0000000000000 8000000000000000 bff0000000000000 00
1 2 1 1 c000000000000000 bff0000000000000 4000000000000000 00
1 1 0 0 ffffffff3f800000 ffffffff3f800000 ffffffffbf800000 00
1 0 0 0 000000003f800000 ffffffffbf800000 ffffffffffc00000 00
2 5 1 1 0000000000000000 8000000000000000 0000000000000001 00
2 6 1 1 bff0000000000000 c000000000000000 0000000000000000 00
2 6 0 0 ffffffff7fc00000 ffffffff3f800000 0000000000000000 10
2 5 1 1 7ff8000000000000 3ff0000000000000 0000000000000000 00
2 5 1 1 7ff0000000000001 3ff0000000000000 0000000000000000 10
3 3 1 1 7ff8000000000000 fff8000000000000 7ff8000000000000 00
3 4 0 0 ffffffff7fc00001 ffffffff7fc00000 ffffffff7fc00000 00
3 3 1 1 7ff0000000000001 4000000000000000 4000000000000000 10
3 3 1 1 0000000000000000 8000000000000000 8000000000000000 00
4 8 1 1 fff0000000000000 0000000000000000 0000000000000001 00
4 8 0 0 ffffffff00000000 0000000000000000 0000000000000010 00
4 8 1 1 7ff0000000000001 0000000000000000 0000000000000100 00
4 8 0 0 000000003f800000 0000000000000000 0000000000000200 00
5 9 0 0 1234567880000001 0000000000000000 ffffffff80000001 00
5 9 1 1 c00921fb54442d18 0000000000000000 c00921fb54442d18 00
5 a 0 0 00000000deadbeef 0000000000000000 ffffffffdeadbeef 00
5 a 1 1 0123456789abcdef 0000000000000000 0123456789abcdef 00
6 6 0 0 ffffffffc0000000 ffffffff3f800000 0000000000000001 00

/* flist.f */
hdl/fp_format_pkg.sv
hdl/fpu_op_pkg.sv
hdl/fpu_operand_unbox.sv
hdl/fpu_compare_unit.sv
hdl/fpu_bitwise_unit.sv
hdl/fpu_result_pipe.sv
hdl/fpu_noncomp_top.sv
dv/fpu_properties.sv
dv/fpu_tb.sv

/* Bender.yml */
package:
  name: fpu_noncomp

sources:
  - files:
      - hdl/fp_format_pkg.sv
      - hdl/fpu_op_pkg.sv
      - hdl/fpu_operand_unbox.sv
      - hdl/fpu_compare_unit.sv
      - hdl/fpu_bitwise_unit.sv
      - hdl/fpu_result_pipe.sv
      - hdl/fpu_noncomp_top.sv
  - target: test
    files:
      - dv/fpu_properties.sv
      - dv/fpu_tb.sv
